//--- verilog/gencon_consts.svh
// calculator core constants
`ifndef GENCON_CONSTS_SVH
`define GENCON_CONSTS_SVH

// full value width including the sign bit
`define GENCON_WIDTH 16
`define GENCON_MAG_WIDTH 15

// keypad side
`define GENCON_DIGIT_WIDTH 4
`define GENCON_OP_WIDTH 3
`define GENCON_RADIX 10

`endif

//--- verilog/gencon_pkg.sv
// calculator core types
`include "gencon_consts.svh"

package gencon_pkg;

    // operator codes as seen on operator_input
    typedef enum logic [`GENCON_OP_WIDTH-1:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // entry controller states
    typedef enum logic [3:0] {
        ENTER_OP1, WAIT_SHIFT_OP1, ADD_DIGIT_OP1,
        ENTER_OP2, WAIT_SHIFT_OP2, ADD_DIGIT_OP2,
        START_EXEC, WAIT_EXEC, SHOW_RESULT
    } state_t;

endpackage

//--- verilog/exec_if.sv
// execute request interface
`timescale 1ns/1ps
`include "gencon_consts.svh"

interface exec_if;
    import gencon_pkg::*;

    // request, held from start until finish
    logic [`GENCON_WIDTH-1:0] a;
    logic [`GENCON_WIDTH-1:0] b;
    op_t                      op;
    logic                     start;

    // response, valid while finish is high
    logic [`GENCON_WIDTH-1:0] result;
    logic                     finish;

    modport ctrl (output a, b, op, start, input result, finish);
    modport exec (input a, b, op, start, output result, finish);

endinterface

//--- verilog/sm_adder.sv
// sign-magnitude adder
`timescale 1ns/1ps
`include "gencon_consts.svh"

module sm_adder (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [`GENCON_WIDTH-1:0] a,
    input  logic [`GENCON_WIDTH-1:0] b,
    input  logic                     sub,
    input  logic                     start,
    output logic [`GENCON_WIDTH-1:0] result,
    output logic                     finish
);
    logic [`GENCON_MAG_WIDTH-1:0] mag_a;
    logic [`GENCON_MAG_WIDTH-1:0] mag_b;
    logic [`GENCON_MAG_WIDTH-1:0] mag_sum;
    logic                         sign_a;
    logic                         sign_b;
    logic                         sign_sum;

    assign mag_a  = a[`GENCON_MAG_WIDTH-1:0];
    assign mag_b  = b[`GENCON_MAG_WIDTH-1:0];
    assign sign_a = a[`GENCON_WIDTH-1];
    // subtraction is addition with b's sign flipped
    assign sign_b = b[`GENCON_WIDTH-1] ^ sub;

    always_comb begin
        if (sign_a == sign_b) begin
            mag_sum  = mag_a + mag_b;
            sign_sum = sign_a;
        end else if (mag_a >= mag_b) begin
            mag_sum  = mag_a - mag_b;
            sign_sum = sign_a;
        end else begin
            mag_sum  = mag_b - mag_a;
            sign_sum = sign_b;
        end
    end

    // zero always reads as +0
    always_ff @(posedge clk) begin
        if (start) begin
            result <= {sign_sum & (|mag_sum), mag_sum};
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

endmodule

//--- verilog/sm_multiplier.sv
// shift-add sign-magnitude multiplier
`timescale 1ns/1ps
`include "gencon_consts.svh"

module sm_multiplier (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [`GENCON_WIDTH-1:0] a,
    input  logic [`GENCON_WIDTH-1:0] b,
    input  logic                     start,
    output logic [`GENCON_WIDTH-1:0] result,
    output logic                     finish
);
    logic                         busy;
    logic [3:0]                   step;
    logic                         sign;
    logic [`GENCON_MAG_WIDTH-1:0] mcand;
    logic [`GENCON_MAG_WIDTH-1:0] mplier;
    logic [`GENCON_MAG_WIDTH-1:0] prod;
    logic [`GENCON_MAG_WIDTH-1:0] prod_next;

    // one partial product per cycle, upper bits drop off for the wrap
    assign prod_next = mplier[0] ? prod + mcand : prod;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else begin
                step <= step + 4'd1;
                // last step also applies the sign
                if (step == 4'(`GENCON_MAG_WIDTH - 1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            mcand  <= a[`GENCON_MAG_WIDTH-1:0];
            mplier <= b[`GENCON_MAG_WIDTH-1:0];
            prod   <= '0;
            sign   <= a[`GENCON_WIDTH-1] ^ b[`GENCON_WIDTH-1];
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            prod   <= prod_next;
            if (step == 4'(`GENCON_MAG_WIDTH - 1)) begin
                result <= {sign & (|prod_next), prod_next};
            end
        end
    end

endmodule

//--- verilog/calc_exec.sv
// execute unit
`timescale 1ns/1ps
`include "gencon_consts.svh"

module calc_exec (
    input  logic clk,
    input  logic nRST,
    exec_if.exec bus
);
    import gencon_pkg::*;

    logic                     add_start;
    logic                     add_sub;
    logic                     add_finish;
    logic [`GENCON_WIDTH-1:0] add_result;
    logic                     mul_start;
    logic                     mul_finish;
    logic [`GENCON_WIDTH-1:0] mul_result;

    // steer the request by opcode
    assign add_start = bus.start && (bus.op == OP_ADD || bus.op == OP_SUB);
    assign add_sub   = (bus.op == OP_SUB);
    assign mul_start = bus.start && (bus.op == OP_MUL);

    sm_adder u_adder (
        .clk    (clk),
        .nRST   (nRST),
        .a      (bus.a),
        .b      (bus.b),
        .sub    (add_sub),
        .start  (add_start),
        .result (add_result),
        .finish (add_finish)
    );

    sm_multiplier u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .a      (bus.a),
        .b      (bus.b),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

    // only one unit is ever running
    assign bus.result = mul_finish ? mul_result : add_result;
    assign bus.finish = add_finish | mul_finish;

endmodule

//--- verilog/gencon.sv
// keypad entry controller
`timescale 1ns/1ps
`include "gencon_consts.svh"

module gencon (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [`GENCON_DIGIT_WIDTH-1:0] keypad_input,
    input  logic                           read_input,
    input  gencon_pkg::op_t                operator_input,
    input  logic                           equal_input,
    output logic                           complete,
    output logic [`GENCON_WIDTH-1:0]       display_output,
    exec_if.ctrl                           bus
);
    import gencon_pkg::*;

    state_t                         state;
    op_t                            op_latched;
    logic [`GENCON_WIDTH-1:0]       operand1;
    logic [`GENCON_WIDTH-1:0]       operand2;
    logic [`GENCON_DIGIT_WIDTH-1:0] digit;
    logic [`GENCON_MAG_WIDTH-1:0]   digit_ext;
    logic                           is_binop;
    logic                           in_entry;

    assign digit_ext  = {{(`GENCON_MAG_WIDTH - `GENCON_DIGIT_WIDTH){1'b0}}, digit};
    assign is_binop   = (operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                        (operator_input == OP_MUL);
    assign in_entry   = (state == ENTER_OP1) || (state == ENTER_OP2);
    assign complete   = (state == SHOW_RESULT);

    // latched operation unless a x10 step is running on the multiplier
    always_comb begin
        bus.a  = operand1;
        bus.b  = operand2;
        bus.op = op_latched;
        if (state == WAIT_SHIFT_OP1) begin
            bus.b  = `GENCON_WIDTH'(`GENCON_RADIX);
            bus.op = OP_MUL;
        end else if (state == WAIT_SHIFT_OP2) begin
            bus.a  = operand2;
            bus.b  = `GENCON_WIDTH'(`GENCON_RADIX);
            bus.op = OP_MUL;
        end
    end

    // digit held for the add after the shift
    always_ff @(posedge clk) begin
        if (in_entry && read_input) begin
            digit <= keypad_input;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_OP1;
            op_latched     <= OP_NONE;
            operand1       <= '0;
            operand2       <= '0;
            display_output <= '0;
            bus.start      <= 1'b0;
        end else begin
            bus.start <= 1'b0;
            case (state)
                ENTER_OP1: begin
                    if (operator_input == OP_NEG) begin
                        operand1[`GENCON_WIDTH-1] <= ~operand1[`GENCON_WIDTH-1];
                    end
                    if (is_binop) begin
                        op_latched <= operator_input;
                        state      <= ENTER_OP2;
                    end else if (read_input) begin
                        bus.start <= 1'b1;
                        state     <= WAIT_SHIFT_OP1;
                    end
                end
                WAIT_SHIFT_OP1: begin
                    // sign stays as keyed even on a zero magnitude
                    if (bus.finish) begin
                        operand1[`GENCON_MAG_WIDTH-1:0] <= bus.result[`GENCON_MAG_WIDTH-1:0];
                        state <= ADD_DIGIT_OP1;
                    end
                end
                ADD_DIGIT_OP1: begin
                    operand1[`GENCON_MAG_WIDTH-1:0] <=
                        operand1[`GENCON_MAG_WIDTH-1:0] + digit_ext;
                    state <= ENTER_OP1;
                end
                ENTER_OP2: begin
                    if (operator_input == OP_NEG) begin
                        operand2[`GENCON_WIDTH-1] <= ~operand2[`GENCON_WIDTH-1];
                    end
                    if (equal_input) begin
                        state <= START_EXEC;
                    end else if (read_input) begin
                        bus.start <= 1'b1;
                        state     <= WAIT_SHIFT_OP2;
                    end
                end
                WAIT_SHIFT_OP2: begin
                    if (bus.finish) begin
                        operand2[`GENCON_MAG_WIDTH-1:0] <= bus.result[`GENCON_MAG_WIDTH-1:0];
                        state <= ADD_DIGIT_OP2;
                    end
                end
                ADD_DIGIT_OP2: begin
                    operand2[`GENCON_MAG_WIDTH-1:0] <=
                        operand2[`GENCON_MAG_WIDTH-1:0] + digit_ext;
                    state <= ENTER_OP2;
                end
                START_EXEC: begin
                    bus.start <= 1'b1;
                    state     <= WAIT_EXEC;
                end
                WAIT_EXEC: begin
                    // result shown and operands cleared for the next calculation
                    if (bus.finish) begin
                        display_output <= bus.result;
                        operand1       <= '0;
                        operand2       <= '0;
                        op_latched     <= OP_NONE;
                        state          <= SHOW_RESULT;
                    end
                end
                SHOW_RESULT: begin
                    state <= ENTER_OP1;
                end
                default: begin
                    state <= ENTER_OP1;
                end
            endcase
        end
    end

endmodule

//--- verilog/gencon_top.sv
// calculator core top level
`timescale 1ns/1ps
`include "gencon_consts.svh"

module gencon_top (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [`GENCON_DIGIT_WIDTH-1:0] keypad_input,
    input  logic                           read_input,
    input  logic [`GENCON_OP_WIDTH-1:0]    operator_input,
    input  logic                           equal_input,
    output logic                           complete,
    output logic [`GENCON_WIDTH-1:0]       display_output
);
    import gencon_pkg::*;

    exec_if bus ();

    gencon u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (op_t'(operator_input)),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output),
        .bus            (bus)
    );

    calc_exec u_exec (
        .clk  (clk),
        .nRST (nRST),
        .bus  (bus)
    );

endmodule

//--- tests/gencon_chk.sv
// calculator protocol checks
`timescale 1ns/1ps
`include "gencon_consts.svh"

module gencon_chk (
    input logic                     clk,
    input logic                     nRST,
    input logic                     start,
    input logic                     finish,
    input logic                     complete,
    input logic [`GENCON_WIDTH-1:0] display_output
);
    logic outstanding;
    logic start_len_bad = 1'b0;
    logic start_overlap_bad = 1'b0;
    logic complete_len_bad = 1'b0;
    logic reset_bad = 1'b0;
    logic assert_failed;

    assign assert_failed = start_len_bad | start_overlap_bad | complete_len_bad | reset_bad;

    // request open from start until finish
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            outstanding <= 1'b0;
        end else if (start) begin
            outstanding <= 1'b1;
        end else if (finish) begin
            outstanding <= 1'b0;
        end
    end

    start_pulse: assert property (@(posedge clk) disable iff (!nRST) start |=> !start)
        else begin
            $error("exec start lasted more than one cycle");
            start_len_bad = 1'b1;
        end

    start_overlap: assert property (@(posedge clk) disable iff (!nRST) start |-> !outstanding)
        else begin
            $error("exec start issued before finish of the previous request");
            start_overlap_bad = 1'b1;
        end

    complete_pulse: assert property (@(posedge clk) disable iff (!nRST) complete |=> !complete)
        else begin
            $error("complete lasted more than one cycle");
            complete_len_bad = 1'b1;
        end

    reset_quiet: assert property (@(posedge clk) !nRST |-> (!complete && display_output == '0))
        else begin
            $error("complete or display active during reset");
            reset_bad = 1'b1;
        end

endmodule

bind gencon gencon_chk u_chk (
    .clk            (clk),
    .nRST           (nRST),
    .start          (bus.start),
    .finish         (bus.finish),
    .complete       (complete),
    .display_output (display_output)
);

//--- tests/gencon_tb.sv
// calculator core testbench
`timescale 1ns/1ps
`include "gencon_consts.svh"

module gencon_tb;
    import gencon_pkg::*;

    localparam int HALF_PERIOD = 10;
    localparam int ENTRY_WAIT = 24;
    localparam int RANDOM_OPS = 40;
    localparam int OP_CYCLES = 250;
    // factor of two leaves room for the directed calculations
    localparam int TIMEOUT_CYCLES = RANDOM_OPS * OP_CYCLES * 2;

    logic                           clk = 1'b0;
    logic                           nRST;
    logic [`GENCON_DIGIT_WIDTH-1:0] keypad_input;
    logic                           read_input;
    logic [`GENCON_OP_WIDTH-1:0]    operator_input;
    logic                           equal_input;
    logic                           complete;
    logic [`GENCON_WIDTH-1:0]       display_output;

    // operand model and pending expectations
    logic [`GENCON_WIDTH-1:0] op_model [2];
    int                       cur = 0;
    op_t                      latched_op = OP_NONE;
    logic [`GENCON_WIDTH-1:0] exp_queue [$];
    string                    name_queue [$];
    logic [`GENCON_WIDTH-1:0] last_expected = '0;
    logic [`GENCON_WIDTH-1:0] shown = '0;
    logic [`GENCON_WIDTH-1:0] cur_exp;
    string                    cur_name;
    logic [31:0]              lfsr = 32'hc00f_702b;
    int                       cycle_count = 0;

    gencon_top UUT (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #HALF_PERIOD clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // sign-magnitude result as the calculator should show it
    function automatic logic [`GENCON_WIDTH-1:0] expected_result(
        input logic [`GENCON_WIDTH-1:0] a,
        input logic [`GENCON_WIDTH-1:0] b,
        input op_t                      op
    );
        logic                           sa;
        logic                           sb;
        logic                           sr;
        logic [`GENCON_MAG_WIDTH-1:0]   ma;
        logic [`GENCON_MAG_WIDTH-1:0]   mb;
        logic [`GENCON_MAG_WIDTH-1:0]   mr;
        logic [2*`GENCON_MAG_WIDTH-1:0] prod;
        sa = a[`GENCON_WIDTH-1];
        sb = b[`GENCON_WIDTH-1] ^ (op == OP_SUB);
        ma = a[`GENCON_MAG_WIDTH-1:0];
        mb = b[`GENCON_MAG_WIDTH-1:0];
        if (op == OP_MUL) begin
            prod = {{`GENCON_MAG_WIDTH{1'b0}}, ma} * {{`GENCON_MAG_WIDTH{1'b0}}, mb};
            mr = prod[`GENCON_MAG_WIDTH-1:0];
            sr = a[`GENCON_WIDTH-1] ^ b[`GENCON_WIDTH-1];
        end else if (sa == sb) begin
            mr = ma + mb;
            sr = sa;
        end else if (ma >= mb) begin
            mr = ma - mb;
            sr = sa;
        end else begin
            mr = mb - ma;
            sr = sb;
        end
        return {sr & (mr != '0), mr};
    endfunction

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [`GENCON_WIDTH-1:0] expected,
                               input logic [`GENCON_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic key_digit(input logic [`GENCON_DIGIT_WIDTH-1:0] d);
        int m;
        next_cycle();
        keypad_input = d;
        read_input = 1'b1;
        next_cycle();
        read_input = 1'b0;
        m = (int'(op_model[cur][`GENCON_MAG_WIDTH-1:0]) * `GENCON_RADIX + int'(d))
            % (1 << `GENCON_MAG_WIDTH);
        op_model[cur][`GENCON_MAG_WIDTH-1:0] = `GENCON_MAG_WIDTH'(m);
        repeat (ENTRY_WAIT - 1) next_cycle();
    endtask

    task automatic key_value(input int v);
        int digits [$];
        int rest;
        rest = v;
        do begin
            digits.push_front(rest % `GENCON_RADIX);
            rest = rest / `GENCON_RADIX;
        end while (rest > 0);
        foreach (digits[i]) begin
            key_digit(`GENCON_DIGIT_WIDTH'(digits[i]));
        end
    endtask

    task automatic press_operator(input op_t op);
        next_cycle();
        operator_input = op;
        next_cycle();
        operator_input = OP_NONE;
        if (op == OP_NEG) begin
            op_model[cur][`GENCON_WIDTH-1] = ~op_model[cur][`GENCON_WIDTH-1];
        end else if (cur == 0 && op != OP_NONE) begin
            latched_op = op;
            cur = 1;
        end
    endtask

    // equal strobe and wait for the complete pulse
    task automatic finish_calc(input string name);
        logic [`GENCON_WIDTH-1:0] expected;
        expected = expected_result(op_model[0], op_model[1], latched_op);
        exp_queue.push_back(expected);
        name_queue.push_back(name);
        last_expected = expected;
        next_cycle();
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
        @(negedge clk);
        while (complete !== 1'b1) begin
            @(negedge clk);
        end
        op_model[0] = '0;
        op_model[1] = '0;
        cur = 0;
        latched_op = OP_NONE;
    endtask

    task automatic run_calc(input string name, input int a, input bit neg_a, input op_t op,
                            input int b, input bit neg_b);
        key_value(a);
        if (neg_a) press_operator(OP_NEG);
        press_operator(op);
        key_value(b);
        if (neg_b) press_operator(OP_NEG);
        finish_calc(name);
    endtask

    // results sampled on the falling edge
    always @(negedge clk) begin
        if (complete === 1'b1) begin
            if (exp_queue.size() == 0) begin
                $display("complete pulse seen with no calculation pending");
                stop_with_failure();
            end else begin
                cur_exp = exp_queue.pop_front();
                cur_name = name_queue.pop_front();
                check_value(cur_name, cur_exp, display_output);
                shown = display_output;
            end
        end else if (display_output !== shown) begin
            $display("display_output changed without a complete pulse");
            stop_with_failure();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles waiting for the calculator", cycle_count);
            stop_with_failure();
        end
    end

    initial begin
        logic [31:0] bits;
        int          count;
        op_t         op_pick;
        op_model[0] = '0;
        op_model[1] = '0;
        nRST = 1'b0;
        keypad_input = '0;
        read_input = 1'b0;
        operator_input = OP_NONE;
        equal_input = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        nRST = 1'b1;

        check_value("reset complete", '0, {{(`GENCON_WIDTH-1){1'b0}}, complete});
        check_value("reset display", '0, display_output);
        // idle stretch where any complete pulse is an error
        repeat (50) next_cycle();

        run_calc("add 123+45", 123, 1'b0, OP_ADD, 45, 1'b0);
        run_calc("sub 9-4 after clear", 9, 1'b0, OP_SUB, 4, 1'b0);
        run_calc("sub 7-20", 7, 1'b0, OP_SUB, 20, 1'b0);
        run_calc("add -5+5", 5, 1'b1, OP_ADD, 5, 1'b0);
        run_calc("mul 300*200 wrap", 300, 1'b0, OP_MUL, 200, 1'b0);
        run_calc("mul -6*7", 6, 1'b1, OP_MUL, 7, 1'b0);

        // display holds while the next operands are keyed
        key_digit(4'd4);
        check_value("display hold op1", last_expected, display_output);
        key_digit(4'd2);
        press_operator(OP_MUL);
        key_digit(4'd3);
        check_value("display hold op2", last_expected, display_output);
        finish_calc("mul 42*3");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            for (int k = 0; k < 2; k++) begin
                take_bits(2, bits);
                count = int'(bits) + 1;
                for (int j = 0; j < count; j++) begin
                    take_bits(4, bits);
                    key_digit(`GENCON_DIGIT_WIDTH'(bits % 10));
                end
                take_bits(1, bits);
                if (bits[0]) press_operator(OP_NEG);
                if (k == 0) begin
                    take_bits(2, bits);
                    op_pick = (bits[1:0] == 2'd0) ? OP_ADD :
                              (bits[1:0] == 2'd1) ? OP_SUB : OP_MUL;
                    press_operator(op_pick);
                end
            end
            finish_calc($sformatf("random %0d", n));
        end

        repeat (5) next_cycle();
        if (UUT.u_ctrl.u_chk.assert_failed) begin
            $display("a protocol assertion failed");
            stop_with_failure();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/gencon_pkg.sv
verilog/exec_if.sv
verilog/sm_adder.sv
verilog/sm_multiplier.sv
verilog/calc_exec.sv
verilog/gencon.sv
verilog/gencon_top.sv
tests/gencon_chk.sv
tests/gencon_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := gencon_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, whatever the simulator exit code was
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
